// ==== sources.f ====
+incdir+source
source/pipe_pkg.sv
source/bus_pkg.sv
source/lsu_align.sv
source/write_buffer.sv
source/data_ram.sv
source/memory_stage.sv
source/memory_top.sv
verif/memory_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module memory_top_tb -f sources.f -o memory_top_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/memory_top_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== verif/memory_top_tb.sv ====
`include "mem_settings.svh"

module memory_top_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import pipe_pkg::*;

  localparam int ram_bytes = 4 * `MEM_RAM_WORDS;
  localparam int wait_limit = 50;

  logic          clk = 1'b0;
  logic          rst;
  mem_req_type   req;
  logic          clear;
  reg_write_type reg_write;
  logic          stall;

  logic [7:0]    model [ram_bytes];  // byte image of the data RAM.
  reg_write_type exp_q [$];          // write-backs still due, in program order.
  integer        seed = 32'h4453a6f1;
  string         test_name = "reset";
  int            errors = 0;
  int            errors_at_start = 0;
  int            tests_run = 0;
  int            tests_bad = 0;
  logic          saw_stall = 1'b0;

  memory_top memory_top_inst (
    .clk(clk), .rst(rst), .req(req), .clear(clear), .reg_write(reg_write), .stall(stall)
  );

  always #4 clk = ~clk;

  function automatic mem_req_type load_req(input lsu_op_type op, input logic [31:0] addr,
                                           input logic [4:0] rd);
    mem_req_type q;
    q = '0;
    q.load = 1'b1;
    q.addr = addr;
    q.lsu_op = op;
    q.waddr = rd;
    return q;
  endfunction

  function automatic mem_req_type store_req(input lsu_op_type op, input logic [31:0] addr,
                                            input logic [31:0] data);
    mem_req_type q;
    q = '0;
    q.store = 1'b1;
    q.addr = addr;
    q.sdata = data;
    q.lsu_op = op;
    return q;
  endfunction

  function automatic mem_req_type fence_req();
    mem_req_type q;
    q = '0;
    q.fence = 1'b1;
    return q;
  endfunction

  function automatic mem_req_type alu_req(input logic [4:0] rd, input logic [31:0] data);
    mem_req_type q;
    q = '0;
    q.wren = 1'b1;
    q.waddr = rd;
    q.wdata = data;
    return q;
  endfunction

  // little endian, and a misaligned half or word falls back to its aligned lane.
  function automatic logic [31:0] load_value(input lsu_op_type op, input logic [31:0] addr);
    int          a;
    logic [7:0]  b;
    logic [15:0] h;
    a = int'(addr) % ram_bytes;
    b = model[a];
    h = {model[a - a % 2 + 1], model[a - a % 2]};
    case (op)
      lsu_lb:  return {{24{b[7]}}, b};
      lsu_lbu: return {24'h000000, b};
      lsu_lh:  return {{16{h[15]}}, h};
      lsu_lhu: return {16'h0000, h};
      default: return {model[a - a % 4 + 3], model[a - a % 4 + 2],
                       model[a - a % 4 + 1], model[a - a % 4]};
    endcase
  endfunction

  task automatic model_store(input lsu_op_type op, input logic [31:0] addr,
                             input logic [31:0] data);
    int a;
    int i;
    a = int'(addr) % ram_bytes;
    case (op)
      lsu_sb: model[a] = data[7:0];
      lsu_sh: for (i = 0; i < 2; i++) model[a - a % 2 + i] = data[8*i +: 8];
      lsu_sw: for (i = 0; i < 4; i++) model[a - a % 4 + i] = data[8*i +: 8];
      default: ;
    endcase
  endtask

  task automatic wait_stall_low(input string what);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (stall && t < wait_limit);
    if (stall) begin
      $display("%s: stall stayed high for %0d cycles %s", test_name, wait_limit, what);
      errors++;
    end
  endtask

  // called on a rising edge, returns on the edge where the stage takes the request.
  task automatic present(input mem_req_type q, input bit wb_due);
    reg_write_type e;
    req <= q;
    if (q.store) model_store(q.lsu_op, q.addr, q.sdata);
    e.wren = 1'b1;
    e.waddr = q.waddr;
    e.wdata = q.load ? load_value(q.lsu_op, q.addr) : q.wdata;
    if (wb_due && ((q.load && q.waddr != 5'd0) || (!q.load && !q.store && !q.fence && q.wren)))
      exp_q.push_back(e);  // x0 loads, stores and fences write nothing back.
    wait_stall_low("while the request waited to be taken");
    @(posedge clk);
  endtask

  task automatic drain();
    int t;
    req <= '0;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while ((stall || exp_q.size() != 0) && t < wait_limit);
    if (stall || exp_q.size() != 0) begin
      $display("%s: pipeline did not settle in %0d cycles, %0d write-backs outstanding",
               test_name, wait_limit, exp_q.size());
      errors++;
      exp_q.delete();
    end
    @(posedge clk);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    drain();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_bad++;
      $display("test %s: FAILED with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  // every write-back is matched in order against what the model predicted.
  always @(negedge clk) begin
    reg_write_type e;
    if (rst) begin
      if (stall) saw_stall = 1'b1;
      assert (!(reg_write.wren && stall)) else begin
        $display("%s: write-back raised while stall was high", test_name);
        errors++;
      end
      if (reg_write.wren) begin
        assert (exp_q.size() != 0) else begin
          $display("%s: register write to x%0d when none was expected", test_name,
                   reg_write.waddr);
          errors++;
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          assert (reg_write == e) else begin
            $display("[ERROR] %s: expected x%0d=%h, actual x%0d=%h", test_name, e.waddr,
                     e.wdata, reg_write.waddr, reg_write.wdata);
            errors++;
          end
        end
      end
    end
  end

  task automatic word_round_trip();
    int i;
    start_test("word_round_trip");
    for (i = 0; i < 4; i++) present(store_req(lsu_sw, 32'h0f0 * i, $random(seed)), 1'b1);
    for (i = 0; i < 4; i++) present(load_req(lsu_lw, 32'h0f0 * i, 5'(i + 1)), 1'b1);
    end_test();
  endtask

  task automatic subword_loads();
    int off;
    start_test("subword_loads");
    present(store_req(lsu_sw, 32'h040, 32'h7c80f105), 1'b1);  // lanes of both signs.
    for (off = 0; off < 4; off++) begin
      present(load_req(lsu_lb, 32'h040 + off, 5'd5), 1'b1);
      present(load_req(lsu_lbu, 32'h040 + off, 5'd6), 1'b1);
      if (off % 2 == 0) begin
        present(load_req(lsu_lh, 32'h040 + off, 5'd7), 1'b1);
        present(load_req(lsu_lhu, 32'h040 + off, 5'd8), 1'b1);
      end
    end
    end_test();
  endtask

  task automatic subword_stores();
    start_test("subword_stores");
    present(store_req(lsu_sw, 32'h080, $random(seed)), 1'b1);
    present(store_req(lsu_sb, 32'h081, $random(seed)), 1'b1);
    present(store_req(lsu_sh, 32'h082, $random(seed)), 1'b1);
    present(load_req(lsu_lw, 32'h080, 5'd12), 1'b1);
    present(store_req(lsu_sh, 32'h083, $random(seed)), 1'b1);  // lands in the upper half.
    present(store_req(lsu_sb, 32'h080, $random(seed)), 1'b1);
    present(load_req(lsu_lw, 32'h080, 5'd13), 1'b1);
    end_test();
  endtask

  task automatic back_pressure();
    int i;
    start_test("back_pressure");
    saw_stall = 1'b0;
    for (i = 0; i < 6; i++) present(store_req(lsu_sw, 32'h100 + 4 * i, $random(seed)), 1'b1);
    present(fence_req(), 1'b1);
    for (i = 0; i < 6; i++) present(load_req(lsu_lw, 32'h100 + 4 * i, 5'(10 + i)), 1'b1);
    present(store_req(lsu_sw, 32'h104, $random(seed)), 1'b1);  // store right behind a load.
    present(load_req(lsu_lw, 32'h104, 5'd20), 1'b1);
    drain();
    assert (saw_stall) else begin
      $display("%s: stall never went high during the burst", test_name);
      errors++;
    end
    end_test();
  endtask

  task automatic x0_and_pass_through();
    logic [31:0] wd;
    start_test("x0_and_pass_through");
    present(load_req(lsu_lw, 32'h000, 5'd0), 1'b1);
    wd = $random(seed);
    present(alu_req(5'd7, wd), 1'b1);
    req <= '0;
    @(negedge clk);
    assert (reg_write.wren && reg_write.waddr == 5'd7 && reg_write.wdata == wd) else begin
      $display("[ERROR] %s: expected wren=1 x7=%h, actual wren=%b x%0d=%h", test_name, wd,
               reg_write.wren, reg_write.waddr, reg_write.wdata);
      errors++;
    end
    @(posedge clk);
    end_test();
  endtask

  task automatic clear_kills_write();
    start_test("clear_kills_write");
    present(load_req(lsu_lw, 32'h0f0, 5'd9), 1'b0);
    req <= '0;
    clear <= 1'b1;  // held through the load's write-back cycle.
    wait_stall_low("while the cleared load waited for its data");
    @(posedge clk);
    clear <= 1'b0;
    present(load_req(lsu_lw, 32'h0f0, 5'd9), 1'b1);
    end_test();
  endtask

  initial begin
    rst = 1'b0;
    req = '0;
    clear = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    word_round_trip();
    subword_loads();
    subword_stores();
    back_pressure();
    x0_and_pass_through();
    clear_kills_write();
    $display("tests run: %0d, tests with errors: %0d, failed checks: %0d", tests_run,
             tests_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== source/memory_top.sv ====
`include "mem_settings.svh"

module memory_top (
  input  logic                    clk,
  input  logic                    rst,
  input  pipe_pkg::mem_req_type   req,
  input  logic                    clear,
  output pipe_pkg::reg_write_type reg_write,
  output logic                    stall
);
  import pipe_pkg::*;
  import bus_pkg::*;

  bus_req_type                bus_req;
  bus_rsp_type                bus_rsp;
  lsu_op_type                 align_op;
  logic [1:0]                 align_offset;
  logic [`MEM_XLEN-1:0]       store_raw;
  logic [`MEM_XLEN-1:0]       store_data;
  logic [`MEM_XLEN/8-1:0]     store_strb;
  logic [`MEM_XLEN-1:0]       load_raw;
  logic [`MEM_XLEN-1:0]       load_result;
  logic [`MEM_XLEN/8-1:0]     ram_we;
  logic [`MEM_RAM_AWIDTH-1:0] ram_addr;
  logic [`MEM_XLEN-1:0]       ram_wdata;
  logic [`MEM_XLEN-1:0]       ram_rdata;

  memory_stage memory_stage_inst (
    .clk(clk), .rst(rst), .req(req), .clear(clear),
    .bus_req(bus_req), .bus_rsp(bus_rsp),
    .align_op(align_op), .align_offset(align_offset),
    .store_raw(store_raw), .store_data(store_data), .store_strb(store_strb),
    .load_raw(load_raw), .load_result(load_result),
    .reg_write(reg_write), .stall(stall)
  );

  lsu_align lsu_align_inst (
    .op(align_op), .offset(align_offset),
    .store_raw(store_raw), .store_data(store_data), .store_strb(store_strb),
    .load_raw(load_raw), .load_result(load_result)
  );

  write_buffer write_buffer_inst (
    .clk(clk), .rst(rst), .bus_req(bus_req), .bus_rsp(bus_rsp),
    .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
  );

  data_ram data_ram_inst (
    .clk(clk), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
  );

endmodule

// ==== source/memory_stage.sv ====
`include "mem_settings.svh"

module memory_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  pipe_pkg::mem_req_type   req,
  input  logic                    clear,
  output bus_pkg::bus_req_type    bus_req,
  input  bus_pkg::bus_rsp_type    bus_rsp,
  output pipe_pkg::lsu_op_type    align_op,
  output logic [1:0]              align_offset,
  output logic [`MEM_XLEN-1:0]    store_raw,
  input  logic [`MEM_XLEN-1:0]    store_data,
  input  logic [`MEM_XLEN/8-1:0]  store_strb,
  output logic [`MEM_XLEN-1:0]    load_raw,
  input  logic [`MEM_XLEN-1:0]    load_result,
  output pipe_pkg::reg_write_type reg_write,
  output logic                    stall
);
  import pipe_pkg::*;
  import bus_pkg::*;

  typedef struct packed {
    logic        kill;  // clear arrived while the instruction was stalled.
    mem_req_type req;
  } stage_reg_type;

  stage_reg_type r;
  stage_reg_type rin;
  mem_req_type   src;
  mem_req_type   align_src;
  logic          r_mem;
  logic          hold_issue;

  always_comb begin
    r_mem = r.req.load | r.req.store | r.req.fence;
    stall = r_mem & ~bus_rsp.ready;  // no response yet for the op in the stage.

    // while stalled the staged op is retried, otherwise the new request goes out.
    src = stall ? r.req : req;

    // a staged load owns the alignment unit for its result, so a store
    // behind it waits one cycle and is retried from the stage register.
    hold_issue = ~stall & r.req.load & req.store;
    align_src = (stall | r.req.load) ? r.req : req;

    align_op = align_src.lsu_op;
    align_offset = align_src.addr[1:0];
    store_raw = align_src.sdata;
    load_raw = bus_rsp.rdata;

    bus_req.valid = (src.load | src.store | src.fence) & ~hold_issue;
    bus_req.fence = src.fence;
    bus_req.addr = src.addr[`MEM_AWIDTH-1:2];
    bus_req.wdata = store_data;
    bus_req.wstrb = src.store ? store_strb : '0;

    reg_write.waddr = r.req.waddr;
    if (r_mem) begin
      reg_write.wren = r.req.load & (|r.req.waddr);  // x0 is never written.
      reg_write.wdata = load_result;
    end else begin
      reg_write.wren = r.req.wren;
      reg_write.wdata = r.req.wdata;
    end
    if (stall | clear | r.kill) begin
      reg_write.wren = 1'b0;
    end

    rin = r;
    if (stall) begin
      rin.kill = r.kill | clear;
    end else begin
      rin.req = req;
      rin.kill = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r <= '0;
    end else begin
      r <= rin;
    end
  end

  // a bus response only ever arrives for the memory op held in the stage.
  a_ready_for_staged_op: assert property (
    @(posedge clk) disable iff (!rst) bus_rsp.ready |-> r_mem
  );

  // the execute stage must hold its request for as long as the stall lasts.
  a_req_held: assert property (
    @(posedge clk) disable iff (!rst) stall |=> $stable(req)
  );

endmodule

// ==== source/data_ram.sv ====
`include "mem_settings.svh"

module data_ram (
  input  logic                       clk,
  input  logic [`MEM_XLEN/8-1:0]     we,
  input  logic [`MEM_RAM_AWIDTH-1:0] addr,
  input  logic [`MEM_XLEN-1:0]       wdata,
  output logic [`MEM_XLEN-1:0]       rdata
);

  logic [`MEM_XLEN-1:0] mem [`MEM_RAM_WORDS];

  always_ff @(posedge clk) begin
    for (int i = 0; i < `MEM_XLEN / 8; i++) begin
      if (we[i]) begin
        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
    rdata <= mem[addr];  // old data on a same-cycle write.
  end

endmodule

// ==== source/write_buffer.sv ====
`include "mem_settings.svh"

module write_buffer (
  input  logic                        clk,
  input  logic                        rst,
  input  bus_pkg::bus_req_type        bus_req,
  output bus_pkg::bus_rsp_type        bus_rsp,
  output logic [`MEM_XLEN/8-1:0]      ram_we,
  output logic [`MEM_RAM_AWIDTH-1:0]  ram_addr,
  output logic [`MEM_XLEN-1:0]        ram_wdata,
  input  logic [`MEM_XLEN-1:0]        ram_rdata
);
  import bus_pkg::*;

  localparam int depth = `MEM_WB_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  wb_entry_type queue [depth];
  wb_entry_type entry_in;

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [ptr_w:0]   count;
  logic             full;
  logic             empty;
  logic             is_store;
  logic             is_wait;
  logic             enq;
  logic             deq;
  logic             accept;
  logic             ready;

  always_comb begin
    full = count == (ptr_w + 1)'(depth);
    empty = count == '0;
    is_store = bus_req.valid & ~bus_req.fence & (|bus_req.wstrb);
    is_wait = bus_req.valid & ~is_store;  // load or fence.

    // reads and fences only go once every older store is in the RAM.
    enq = is_store & ~full;
    deq = ~empty;
    accept = enq | (is_wait & empty);

    entry_in.addr = bus_req.addr;
    entry_in.data = bus_req.wdata;
    entry_in.strb = bus_req.wstrb;

    ram_we = deq ? queue[head].strb : '0;
    ram_addr = deq ? queue[head].addr[`MEM_RAM_AWIDTH-1:0]
                   : bus_req.addr[`MEM_RAM_AWIDTH-1:0];
    ram_wdata = queue[head].data;

    bus_rsp.ready = ready;
    bus_rsp.rdata = ram_rdata;  // read data lines up with ready.
  end

  always_ff @(posedge clk) begin
    if (enq) begin
      queue[tail] <= entry_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      ready <= 1'b0;
    end else begin
      ready <= accept;
      if (enq) begin
        tail <= (tail == ptr_w'(depth - 1)) ? '0 : tail + 1'b1;
      end
      if (deq) begin
        head <= (head == ptr_w'(depth - 1)) ? '0 : head + 1'b1;
      end
      count <= count + (ptr_w + 1)'(enq) - (ptr_w + 1)'(deq);
    end
  end

  // the count agrees with the pointers, so the queue can never overrun.
  a_count_ptrs: assert property (
    @(posedge clk) disable iff (!rst)
      (count <= (ptr_w + 1)'(depth)) && ((head == tail) == (empty | full))
  );

endmodule

// ==== source/lsu_align.sv ====
`include "mem_settings.svh"

module lsu_align (
  input  pipe_pkg::lsu_op_type   op,
  input  logic [1:0]             offset,
  input  logic [`MEM_XLEN-1:0]   store_raw,
  output logic [`MEM_XLEN-1:0]   store_data,
  output logic [`MEM_XLEN/8-1:0] store_strb,
  input  logic [`MEM_XLEN-1:0]   load_raw,
  output logic [`MEM_XLEN-1:0]   load_result
);
  import pipe_pkg::*;

  localparam int strb_w = `MEM_XLEN / 8;

  logic [`MEM_XLEN-1:0] shifted;
  logic [7:0]           byte_lane;
  logic [15:0]          half_lane;

  // the lane is replicated so the strobe alone picks the bytes written.
  always_comb begin
    store_data = store_raw;
    store_strb = '0;
    case (op)
      lsu_sb: begin
        store_data = {(`MEM_XLEN / 8){store_raw[7:0]}};
        store_strb = strb_w'(1) << offset;
      end
      lsu_sh: begin
        store_data = {(`MEM_XLEN / 16){store_raw[15:0]}};
        store_strb = strb_w'(3) << {offset[1], 1'b0};  // low offset bit is masked.
      end
      lsu_sw: store_strb = '1;
      default: store_strb = '0;  // loads write nothing.
    endcase
  end

  always_comb begin
    shifted = load_raw >> {offset, 3'b000};
    byte_lane = shifted[7:0];
    half_lane = offset[1] ? load_raw[31:16] : load_raw[15:0];
    case (op)
      lsu_lb:  load_result = {{(`MEM_XLEN - 8){byte_lane[7]}}, byte_lane};
      lsu_lbu: load_result = {{(`MEM_XLEN - 8){1'b0}}, byte_lane};
      lsu_lh:  load_result = {{(`MEM_XLEN - 16){half_lane[15]}}, half_lane};
      lsu_lhu: load_result = {{(`MEM_XLEN - 16){1'b0}}, half_lane};
      default: load_result = load_raw;
    endcase
  end

endmodule

// ==== source/bus_pkg.sv ====
`include "mem_settings.svh"

package bus_pkg;

  // request from the memory stage, a zero strobe with valid set is a read.
  typedef struct packed {
    logic                     valid;
    logic                     fence;
    logic [`MEM_AWIDTH-3:0]   addr;   // word address.
    logic [`MEM_XLEN-1:0]     wdata;
    logic [`MEM_XLEN/8-1:0]   wstrb;
  } bus_req_type;

  typedef struct packed {
    logic                 ready;
    logic [`MEM_XLEN-1:0] rdata;
  } bus_rsp_type;

  // one posted store waiting in the write buffer.
  typedef struct packed {
    logic [`MEM_AWIDTH-3:0]   addr;
    logic [`MEM_XLEN-1:0]     data;
    logic [`MEM_XLEN/8-1:0]   strb;
  } wb_entry_type;

endpackage

// ==== source/pipe_pkg.sv ====
`include "mem_settings.svh"

package pipe_pkg;

  // load/store operation as decoded by the execute stage.
  typedef enum logic [2:0] {
    lsu_lb  = 3'd0,
    lsu_lbu = 3'd1,
    lsu_lh  = 3'd2,
    lsu_lhu = 3'd3,
    lsu_lw  = 3'd4,
    lsu_sb  = 3'd5,
    lsu_sh  = 3'd6,
    lsu_sw  = 3'd7
  } lsu_op_type;

  // one instruction handed from execute to the memory stage.
  typedef struct packed {
    logic                    load;
    logic                    store;
    logic                    fence;
    logic [`MEM_AWIDTH-1:0]  addr;   // byte address.
    logic [`MEM_XLEN-1:0]    sdata;  // store data, not yet lane aligned.
    lsu_op_type              lsu_op;
    logic [4:0]              waddr;
    logic                    wren;   // write-back of a non-memory instruction.
    logic [`MEM_XLEN-1:0]    wdata;
  } mem_req_type;

  // register file write port, also used for forwarding.
  typedef struct packed {
    logic                 wren;
    logic [4:0]           waddr;
    logic [`MEM_XLEN-1:0] wdata;
  } reg_write_type;

endpackage

// ==== source/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data word width in bits.
`define MEM_XLEN 32

// byte address width of the execute request.
`define MEM_AWIDTH 32

// data RAM depth in words and its index width.
`define MEM_RAM_WORDS 256
`define MEM_RAM_AWIDTH $clog2(`MEM_RAM_WORDS)

// number of stores the posted write buffer can hold.
`define MEM_WB_DEPTH 4

`endif
